// File: ack_pkg.sv
package ack_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W = 32;  // n, result, call counter
    localparam int ARG_W  = 8;   // Operands and stack entries

    typedef logic [ARG_W-1:0]  arg_t;
    typedef logic [WORD_W-1:0] word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine to stack link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic push;   // One-cycle strobe
        logic pop;    // One-cycle strobe
        arg_t wdata;  // m value to push
    } stack_req_t;

    typedef struct packed {
        logic rvalid;    // Popped data this cycle
        arg_t rdata;
        logic empty;
        logic overflow;  // Sticky until clr
    } stack_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine FSM encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        IDLE,
        POP,
        WAIT,
        EVAL,
        PUSH_HI,
        HALT
    } eng_state_t;

endpackage

// File: ack_stack_ram.sv
`timescale 1ns/1ps

module ack_stack_ram import ack_pkg::*; #(
    parameter  int STACK_DEPTH = 128,
    localparam int ADDR_W      = $clog2(STACK_DEPTH)
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  arg_t              d,
    output arg_t              q
);

    arg_t mem [0:STACK_DEPTH-1];

    // Single port, write or registered read per enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= d;
            end else begin
                q <= mem[addr];  // Valid the next cycle
            end
        end
    end

endmodule

// File: ack_frame_stack.sv
`timescale 1ns/1ps

module ack_frame_stack import ack_pkg::*; #(
    parameter int STACK_DEPTH = 128
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       clr,
    input  stack_req_t req,
    output stack_rsp_t rsp
);

    localparam int ADDR_W = $clog2(STACK_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;  // Counts 0 .. STACK_DEPTH

    localparam logic [PTR_W-1:0] FULL_CNT = PTR_W'(STACK_DEPTH);

    logic [PTR_W-1:0]  sp;
    logic [PTR_W-1:0]  sp_base;
    logic [PTR_W-1:0]  sp_dec;
    logic              full;
    logic              empty_now;
    logic              do_push;
    logic              do_pop;
    logic              overflow_q;
    logic              rvalid_q;
    logic              ram_en;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    arg_t              ram_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointer arithmetic and RAM control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sp_base   = clr ? '0 : sp;  // A push with clr lands in an empty stack
    assign sp_dec    = sp_base - 1'b1;
    assign full      = (sp_base == FULL_CNT);
    assign empty_now = (sp_base == '0);

    assign do_push = req.push & ~full;
    assign do_pop  = req.pop & ~req.push & ~empty_now;

    assign ram_en   = do_push | do_pop;
    assign ram_we   = do_push;
    assign ram_addr = do_pop ? sp_dec[ADDR_W-1:0] : sp_base[ADDR_W-1:0];  // Pop reads new top

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sp         <= '0;
            overflow_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            rvalid_q <= do_pop;
            if (do_push) begin
                sp <= sp_base + 1'b1;
            end else if (do_pop) begin
                sp <= sp_dec;
            end else begin
                sp <= sp_base;
            end
            overflow_q <= (clr ? 1'b0 : overflow_q) | (req.push & full);  // Dropped push
        end
    end

    ack_stack_ram #(
        .STACK_DEPTH (STACK_DEPTH)
    ) ram_i (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .addr (ram_addr),
        .d    (req.wdata),
        .q    (ram_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response to engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rsp.rvalid   = rvalid_q;
    assign rsp.rdata    = ram_q;
    assign rsp.empty    = (sp == '0);
    assign rsp.overflow = overflow_q;

endmodule

// File: ack_engine.sv
`timescale 1ns/1ps

module ack_engine import ack_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  arg_t       op1,
    input  arg_t       op2,
    input  logic       init,
    output stack_req_t stk_req,
    input  stack_rsp_t stk_rsp,
    output logic       stk_clr,
    output word_t      result,
    output word_t      calls,
    output logic       busy,
    output logic       done,
    output logic       err
);

    logic [1:0] init_sync;
    logic       start;
    logic       run_start;
    eng_state_t state;
    arg_t       m_q;
    word_t      n;
    word_t      n_next;
    logic       m_zero;
    logic       n_zero;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Init synchronizer and start pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstn) begin
            init_sync <= 2'b00;
            start     <= 1'b0;
        end else begin
            init_sync <= {init_sync[0], init};
            start     <= init_sync[0] & ~init_sync[1];  // Rising edge
        end
    end

    assign run_start = start & ~busy;  // Edges during a run are dropped

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Evaluation rule
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign m_zero = (m_q == '0);
    assign n_zero = (n == '0);

    always_comb begin
        if (m_zero) begin
            n_next = n + 1'b1;
        end else if (n_zero) begin
            n_next = word_t'(1);
        end else begin
            n_next = n - 1'b1;
        end
    end

    // Stack requests, at most one per cycle
    always_comb begin
        stk_req = '0;
        stk_clr = run_start;
        case (state)
            POP: begin
                stk_req.pop = ~stk_rsp.overflow & ~stk_rsp.empty;
            end
            EVAL: begin
                stk_req.push  = ~m_zero;  // m-1 for both nonzero cases
                stk_req.wdata = m_q - 1'b1;
            end
            PUSH_HI: begin
                stk_req.push  = 1'b1;
                stk_req.wdata = m_q;
            end
            default: begin
                stk_req.pop = 1'b0;
            end
        endcase
        if (run_start) begin
            stk_req.push  = 1'b1;  // Seed frame, same cycle as clr
            stk_req.wdata = op1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= IDLE;
            busy   <= 1'b0;
            done   <= 1'b0;
            err    <= 1'b0;
            calls  <= '0;
            result <= '0;
        end else begin
            case (state)
                IDLE, HALT: begin
                    if (run_start) begin
                        state <= POP;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                        err   <= 1'b0;
                        calls <= '0;
                    end
                end
                POP: begin
                    if (stk_rsp.overflow) begin
                        state <= HALT;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        err   <= 1'b1;
                    end else if (stk_rsp.empty) begin
                        state <= HALT;  // Final n is the result
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (stk_rsp.rvalid) begin
                        state <= EVAL;
                    end
                end
                EVAL: begin
                    calls  <= calls + 1'b1;
                    result <= n_next;
                    if (!m_zero && !n_zero) begin
                        state <= PUSH_HI;  // m goes on top of m-1
                    end else begin
                        state <= POP;
                    end
                end
                PUSH_HI: begin
                    state <= POP;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Working registers
    always_ff @(posedge clk) begin
        if (run_start) begin
            n <= {{(WORD_W - ARG_W){1'b0}}, op2};
        end else if (state == EVAL) begin
            n <= n_next;
        end
        if (state == WAIT && stk_rsp.rvalid) begin
            m_q <= stk_rsp.rdata;  // Popped m
        end
    end

endmodule

// File: ack_top.sv
`timescale 1ns/1ps

module ack_top import ack_pkg::*; #(
    parameter int STACK_DEPTH = 128
) (
    input  logic  clk,
    input  logic  rstn,
    input  arg_t  op1,
    input  arg_t  op2,
    input  logic  init,
    output word_t result,
    output word_t calls,
    output logic  busy,
    output logic  done,
    output logic  err
);

    stack_req_t stk_req;
    stack_rsp_t stk_rsp;
    logic       stk_clr;

    ack_engine engine_i (
        .clk     (clk),
        .rstn    (rstn),
        .op1     (op1),
        .op2     (op2),
        .init    (init),
        .stk_req (stk_req),
        .stk_rsp (stk_rsp),
        .stk_clr (stk_clr),
        .result  (result),
        .calls   (calls),
        .busy    (busy),
        .done    (done),
        .err     (err)
    );

    ack_frame_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) stack_i (
        .clk  (clk),
        .rstn (rstn),
        .clr  (stk_clr),
        .req  (stk_req),
        .rsp  (stk_rsp)
    );

endmodule

// File: ack_tb_sva.sv
`timescale 1ns/1ps

module ack_sva import ack_pkg::*; (
    input logic  clk,
    input logic  rstn,
    input logic  busy,
    input logic  done,
    input logic  err,
    input word_t result,
    input word_t calls
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    busy_done_exclusive: assert property (
        @(posedge clk) disable iff (!rstn) !(busy && done)
    ) else $error("busy and done are high in the same cycle");

    // err sets on the same edge that drops busy
    err_rise_in_run: assert property (
        @(posedge clk) disable iff (!rstn) $rose(err) |-> $past(busy)
    ) else $error("err rose while no run was active");

    // Start drops done together with the counter clear
    results_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (done && $past(done)) |-> ($stable(result) && $stable(calls))
    ) else $error("result or calls changed while done was high");

endmodule

bind ack_top ack_sva sva_i (
    .clk    (clk),
    .rstn   (rstn),
    .busy   (busy),
    .done   (done),
    .err    (err),
    .result (result),
    .calls  (calls)
);

// File: ack_tb.sv
`timescale 1ns/1ps

module ack_tb import ack_pkg::*; ();

    localparam int TRACE_LEN   = 16;
    localparam int FIELDS      = 6;     // op1 op2 result calls err poke
    localparam int CYCLES_EACH = 4000;  // Watchdog budget per trace line

    logic  clk;
    logic  rstn;
    arg_t  op1;
    arg_t  op2;
    logic  init;
    word_t result;
    word_t calls;
    logic  busy;
    logic  done;
    logic  err;

    logic [31:0] trace_mem [0:TRACE_LEN*FIELDS-1];
    logic [31:0] lcg_state;
    int          done_rises;
    logic        done_seen;
    int          pass_cnt;
    int          fail_cnt;

    ack_top dut_i (
        .clk    (clk),
        .rstn   (rstn),
        .op1    (op1),
        .op2    (op2),
        .init   (init),
        .result (result),
        .calls  (calls),
        .busy   (busy),
        .done   (done),
        .err    (err)
    );

    always #10 clk = ~clk;

    // Counts done rising edges
    always @(posedge clk) begin
        if (!rstn) begin
            done_seen  <= 1'b0;
            done_rises <= 0;
        end else begin
            done_seen <= done;
            if (done && !done_seen) begin
                done_rises <= done_rises + 1;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One run from a trace line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_test(input int idx);
        arg_t  a;
        arg_t  b;
        word_t exp_result;
        word_t exp_calls;
        logic  exp_err;
        logic  poke;
        int    rises_before;
        int    errors;
        word_t calls_mid;
        a            = arg_t'(trace_mem[idx*FIELDS]);
        b            = arg_t'(trace_mem[idx*FIELDS+1]);
        exp_result   = trace_mem[idx*FIELDS+2];
        exp_calls    = trace_mem[idx*FIELDS+3];
        exp_err      = trace_mem[idx*FIELDS+4][0];
        poke         = trace_mem[idx*FIELDS+5][0];
        errors       = 0;
        rises_before = done_rises;

        @(negedge clk);
        op1  = a;
        op2  = b;
        init = 1'b1;
        repeat (2) @(negedge clk);
        init = 1'b0;

        if (poke) begin
            while (!busy) @(negedge clk);
            repeat (40) @(negedge clk);
            calls_mid = calls;
            init      = 1'b1;  // Second edge inside the run
            repeat (2) @(negedge clk);
            init = 1'b0;
            if (!busy) begin
                $display("test %0d: run ended before the extra init pulse was given", idx);
                errors++;
            end
            repeat (4) @(negedge clk);
            if (calls < calls_mid) begin
                $display("test %0d: call count fell back after the init pulse given while busy",
                         idx);
                errors++;
            end
        end

        while (done_rises == rises_before) @(negedge clk);

        if (err !== exp_err) begin
            $display("mismatch err: got 0x%0h expected 0x%0h", err, exp_err);
            errors++;
        end
        if (!exp_err) begin
            if (result !== exp_result) begin
                $display("mismatch result: got 0x%0h expected 0x%0h", result, exp_result);
                errors++;
            end
            if (calls !== exp_calls) begin
                $display("mismatch calls: got 0x%0h expected 0x%0h", calls, exp_calls);
                errors++;
            end
        end

        repeat (8) @(negedge clk);
        if (done_rises != rises_before + 1) begin
            $display("test %0d: saw %0d done rises instead of one",
                     idx, done_rises - rises_before);
            errors++;
        end
        if (!done || busy) begin
            $display("test %0d: done did not stay high after the run", idx);
            errors++;
        end

        if (errors == 0) begin
            pass_cnt++;
            $display("test %0d A(%0d,%0d) err=%0d ok", idx, a, b, exp_err);
        end else begin
            fail_cnt++;
            $display("test %0d A(%0d,%0d) failed with %0d errors", idx, a, b, errors);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        init      = 1'b0;
        op1       = '0;
        op2       = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        lcg_state = 32'd71180;
        $readmemh("ack_trace.txt", trace_mem);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < TRACE_LEN; i++) begin
            run_test(i);
            lcg_state = lcg_next(lcg_state);
            repeat (lcg_state[18:16]) @(negedge clk);  // 0 to 7 idle cycles
        end

        $display("tests run %0d, passed %0d, failed %0d", TRACE_LEN, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (TRACE_LEN * CYCLES_EACH) @(posedge clk);
        $display("run timed out after %0d cycles before all tests finished",
                 TRACE_LEN * CYCLES_EACH);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: ack_trace.txt
// Columns in hex: op1 op2 expected_result expected_calls expected_err poke
// poke 1 gives an extra init pulse while busy; result and calls unchecked when err is 1
0 0 1 1 0 0
0 5 6 1 0 0
0 FF 100 1 0 0
1 0 2 2 0 0
1 1 3 4 0 0
1 4 6 A 0 0
1 A C 16 0 0
2 0 3 5 0 0
2 2 7 1B 0 0
2 3 9 2C 0 0
3 0 5 F 0 0
3 1 D 6A 0 0
3 3 3D 980 0 0
3 5 0 0 1 0
2 1 5 E 0 0
3 3 3D 980 0 1

// File: vlog.f
ack_pkg.sv
ack_stack_ram.sv
ack_frame_stack.sv
ack_engine.sv
ack_top.sv
ack_tb_sva.sv
ack_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ack_tb -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/Vack_tb)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
